//--- project.f
+incdir+design
design/support_pkg.sv
design/obi_phase_monitor.sv
design/req_attribute_fifo.sv
design/core_event_tracker.sv
design/support_logic.sv
verification/tb_support_logic.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, verdict comes from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_support_logic -Mdir obj_dir -f project.f

./obj_dir/Vtb_support_logic > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test OK$" sim.log; then
  exit 0
else
  exit 1
fi

//--- verification/tb_support_logic.sv
`timescale 1ns/1ps
`include "support_consts.svh"

module tb_support_logic;

  localparam int RUN_CYCLES  = 3000;
  localparam int DRAIN_LIMIT = 100;
  localparam int MAX_OUTST   = 4;

  logic                     in_support_if;
  logic                     rst_n;
  // index 0 is the instruction bus, 1 the data bus
  support_pkg::obi_bus_t    bus [2];
  logic                     integrity [2];
  support_pkg::core_ctrl_t  core_ctrl;
  support_pkg::retire_t     retire;
  support_pkg::bus_phase_t  phase [2];
  support_pkg::resp_attr_t  attr;
  support_pkg::core_event_t events;

  int errors;
  int ff_count;
  int fd_count;
  int rae_cycles;

  // stimulus model state
  logic [31:0] lfsr_q;
  int          pend [2];
  int          rwait [2];
  logic        req_on [2];
  logic        traffic_on;
  logic        dbg_state;
  logic        dret_last;

  // reference model state
  int   outst_cnt [2];
  logic addr_ref [2];
  logic resp_ref [2];
  logic par_pend [2];
  bit   store_q [$];
  bit   int_q0 [$];
  bit   int_q1 [$];
  bit   par_q0 [$];
  bit   par_q1 [$];
  logic seen_en;
  logic in_dbg;
  logic dret_pend;
  logic rec_ref;
  int   hold_ref;
  logic exc_act;
  logic data_gnt_prev;
  logic rae_ref;
  // expected combinational outputs, settled at the falling edge
  logic                    exp_par [2];
  support_pkg::resp_attr_t exp_attr;
  logic                    exp_ff;
  logic                    exp_fd;

  support_logic support_logic_inst (
    .in_support_if     (in_support_if),
    .rst_n_i           (rst_n),
    .instr_bus_i       (bus[0]),
    .data_bus_i        (bus[1]),
    .instr_integrity_i (integrity[0]),
    .data_integrity_i  (integrity[1]),
    .core_ctrl_i       (core_ctrl),
    .retire_i          (retire),
    .instr_phase_o     (phase[0]),
    .data_phase_o      (phase[1]),
    .attr_o            (attr),
    .event_o           (events)
  );

  initial begin
    in_support_if = 1'b0;
    forever #2 in_support_if = ~in_support_if;
  end

  // ----------------------------------------
  // random source and bus/core model
  // ----------------------------------------
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) begin
      lfsr_q = lfsr_q ^ 32'h80200003;
    end
    return out;
  endfunction

  function automatic int draw(int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_bit());
    end
    return v;
  endfunction

  task automatic drive_cycle();
    support_pkg::obi_bus_t   nb [2];
    support_pkg::core_ctrl_t nc;
    support_pkg::retire_t    nr;
    logic                    ni [2];
    for (int b = 0; b < 2; b++) begin
      nb[b] = '0;
      // responses first, so only grants of earlier cycles are answered
      if (pend[b] > 0) begin
        if (rwait[b] == 0) begin
          rwait[b] = 1 + draw(2) % 3;
        end
        rwait[b]--;
        if (rwait[b] == 0) begin
          nb[b].rvalid = 1'b1;
          pend[b]--;
        end
      end
      if (!req_on[b] && traffic_on) begin
        req_on[b] = lfsr_bit();
      end
      // req stays up until granted, grant held back at the outstanding cap
      if (req_on[b]) begin
        nb[b].req = 1'b1;
        nb[b].gnt = (pend[b] < MAX_OUTST) && (draw(2) != 0);
        if (nb[b].gnt) begin
          pend[b]++;
          req_on[b] = 1'b0;
        end
      end
      // occasional wrong grant parity
      nb[b].gntpar = !nb[b].gnt ^ (nb[b].req && draw(3) == 0);
      ni[b] = lfsr_bit();
    end
    nc = '0;
    nc.fetch_enable = core_ctrl.fetch_enable || (draw(4) == 0);
    nc.debug_req    = (draw(3) == 0);
    nc.trap_taken   = (draw(4) == 0);
    nc.req_is_store = lfsr_bit();
    nr = '0;
    nr.valid = lfsr_bit();
    if (nr.valid) begin
      // wander into debug now and then, leave only by a clean dret
      if (!dbg_state && draw(3) == 0) begin
        dbg_state = 1'b1;
      end
      nr.dbg_mode = dbg_state;
      nr.trap     = (draw(3) == 0);
      nr.is_dret  = dbg_state && !dret_last && (draw(2) == 0);
      if (nr.is_dret && !nr.trap) begin
        dbg_state = 1'b0;
      end
    end
    dret_last = nr.is_dret;
    bus[0]       <= nb[0];
    bus[1]       <= nb[1];
    integrity[0] <= ni[0];
    integrity[1] <= ni[1];
    core_ctrl    <= nc;
    retire       <= nr;
  endtask

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  always @(posedge in_support_if or negedge rst_n) begin
    logic new_req;
    if (!rst_n) begin
      for (int b = 0; b < 2; b++) begin
        outst_cnt[b] = 0;
        addr_ref[b]  = 1'b0;
        resp_ref[b]  = 1'b0;
        par_pend[b]  = 1'b0;
      end
      store_q.delete();
      int_q0.delete();
      int_q1.delete();
      par_q0.delete();
      par_q1.delete();
      seen_en       = 1'b0;
      in_dbg        = 1'b0;
      dret_pend     = 1'b0;
      rec_ref       = 1'b0;
      hold_ref      = 0;
      exc_act       = 1'b0;
      data_gnt_prev = 1'b0;
      rae_ref       = 1'b0;
    end else begin
      for (int b = 0; b < 2; b++) begin
        addr_ref[b]  = bus[b].req && !bus[b].gnt;
        resp_ref[b]  = (outst_cnt[b] != 0) && !bus[b].rvalid;
        outst_cnt[b] = outst_cnt[b] + int'(bus[b].req && bus[b].gnt) - int'(bus[b].rvalid);
        // parity error sticks while the same request waits
        par_pend[b] = bus[b].req && !bus[b].gnt && exp_par[b];
      end
      // oldest entry leaves with its response, new entry joins on grant
      if (bus[0].rvalid) begin
        void'(int_q0.pop_front());
        void'(par_q0.pop_front());
      end
      if (bus[1].rvalid) begin
        void'(store_q.pop_front());
        void'(int_q1.pop_front());
        void'(par_q1.pop_front());
      end
      if (bus[0].req && bus[0].gnt) begin
        int_q0.push_back(integrity[0]);
        par_q0.push_back(exp_par[0]);
      end
      if (bus[1].req && bus[1].gnt) begin
        store_q.push_back(core_ctrl.req_is_store);
        int_q1.push_back(integrity[1]);
        par_q1.push_back(exp_par[1]);
      end
      new_req       = bus[1].req && data_gnt_prev;
      data_gnt_prev = bus[1].req && bus[1].gnt;
      seen_en       = seen_en || core_ctrl.fetch_enable;
      // a clean dret drops the debug flag one cycle after it retires
      if (retire.valid) begin
        in_dbg = retire.dbg_mode;
      end
      if (dret_pend) begin
        in_dbg = 1'b0;
      end
      dret_pend = retire.valid && retire.is_dret && !retire.trap;
      // debug request window, counted in retirements
      if (retire.valid && core_ctrl.debug_req) begin
        rec_ref  = 1'b1;
        hold_ref = 1;
      end else if (retire.valid) begin
        if (hold_ref > 0) begin
          hold_ref--;
        end else begin
          rec_ref = 1'b0;
        end
      end else if (core_ctrl.debug_req) begin
        rec_ref  = 1'b1;
        hold_ref = `SL_DBG_HOLD;
      end
      if (core_ctrl.trap_taken) begin
        exc_act = 1'b1;
        rae_ref = rae_ref || new_req;
      end else if (retire.valid) begin
        exc_act = 1'b0;
        rae_ref = 1'b0;
      end else if (exc_act && new_req) begin
        rae_ref = 1'b1;
      end
    end
  end

  always @(negedge in_support_if) begin
    for (int b = 0; b < 2; b++) begin
      exp_par[b] = bus[b].req && ((bus[b].gnt == bus[b].gntpar) || par_pend[b]);
    end
    exp_attr.req_was_store = bus[1].rvalid && store_q.size() > 0 && store_q[0];
    exp_attr.instr_req_had_integrity = bus[0].rvalid && int_q0.size() > 0 && int_q0[0];
    exp_attr.data_req_had_integrity = bus[1].rvalid && int_q1.size() > 0 && int_q1[0];
    exp_attr.gntpar_error_in_response_instr = bus[0].rvalid && par_q0.size() > 0 && par_q0[0];
    exp_attr.gntpar_error_in_response_data = bus[1].rvalid && par_q1.size() > 0 && par_q1[0];
    exp_ff = core_ctrl.fetch_enable && !seen_en;
    exp_fd = retire.valid && retire.dbg_mode && !in_dbg;
    if (rst_n) begin
      ff_count   += int'(events.first_fetch);
      fd_count   += int'(events.first_debug_ins);
      rae_cycles += int'(events.req_after_exception);
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------
  task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
    errors++;
    $display("[ERROR] %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual, $time);
  endtask

  for (genvar g = 0; g < 2; g++) begin : bus_checks
    localparam string PORT = (g == 0) ? "instr_phase_o" : "data_phase_o";

    a_outstanding: assert property (@(posedge in_support_if) disable iff (!rst_n)
      int'(phase[g].outstanding) == outst_cnt[g])
      else report_mismatch({PORT, ".outstanding"}, $sampled(outst_cnt[g]),
                           32'($sampled(phase[g].outstanding)));
    a_addr_cont: assert property (@(posedge in_support_if) disable iff (!rst_n)
      phase[g].addr_ph_cont == addr_ref[g])
      else report_mismatch({PORT, ".addr_ph_cont"}, 32'($sampled(addr_ref[g])),
                           32'($sampled(phase[g].addr_ph_cont)));
    a_resp_cont: assert property (@(posedge in_support_if) disable iff (!rst_n)
      phase[g].resp_ph_cont == resp_ref[g])
      else report_mismatch({PORT, ".resp_ph_cont"}, 32'($sampled(resp_ref[g])),
                           32'($sampled(phase[g].resp_ph_cont)));
    a_gntpar_err: assert property (@(posedge in_support_if) disable iff (!rst_n)
      phase[g].gntpar_err == exp_par[g])
      else report_mismatch({PORT, ".gntpar_err"}, 32'($sampled(exp_par[g])),
                           32'($sampled(phase[g].gntpar_err)));
  end

  a_attr: assert property (@(posedge in_support_if) disable iff (!rst_n) attr == exp_attr)
    else report_mismatch("attr_o", 32'($sampled(exp_attr)), 32'($sampled(attr)));
  a_first_fetch: assert property (@(posedge in_support_if) disable iff (!rst_n)
    events.first_fetch == exp_ff)
    else report_mismatch("event_o.first_fetch", 32'($sampled(exp_ff)),
                         32'($sampled(events.first_fetch)));
  a_first_debug: assert property (@(posedge in_support_if) disable iff (!rst_n)
    events.first_debug_ins == exp_fd)
    else report_mismatch("event_o.first_debug_ins", 32'($sampled(exp_fd)),
                         32'($sampled(events.first_debug_ins)));
  a_dbg_req: assert property (@(posedge in_support_if) disable iff (!rst_n)
    events.recorded_dbg_req == rec_ref)
    else report_mismatch("event_o.recorded_dbg_req", 32'($sampled(rec_ref)),
                         32'($sampled(events.recorded_dbg_req)));
  a_req_after_exc: assert property (@(posedge in_support_if) disable iff (!rst_n)
    events.req_after_exception == rae_ref)
    else report_mismatch("event_o.req_after_exception", 32'($sampled(rae_ref)),
                         32'($sampled(events.req_after_exception)));

  // answer every open request, no new ones start
  task automatic drain_buses();
    int waited;
    waited = 0;
    while ((pend[0] > 0 || pend[1] > 0 || req_on[0] || req_on[1]) && waited < DRAIN_LIMIT) begin
      @(posedge in_support_if);
      drive_cycle();
      waited++;
    end
    if (pend[0] > 0 || pend[1] > 0 || req_on[0] || req_on[1]) begin
      errors++;
      $display("timeout: buses still busy after %0d drain cycles", DRAIN_LIMIT);
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    lfsr_q       = 32'h5578e944;
    errors       = 0;
    ff_count     = 0;
    fd_count     = 0;
    rae_cycles   = 0;
    rst_n        = 1'b0;
    bus[0]       = '0;
    bus[1]       = '0;
    integrity[0] = 1'b0;
    integrity[1] = 1'b0;
    core_ctrl    = '0;
    retire       = '0;
    for (int b = 0; b < 2; b++) begin
      pend[b]   = 0;
      rwait[b]  = 0;
      req_on[b] = 1'b0;
    end
    traffic_on = 1'b1;
    dbg_state  = 1'b0;
    dret_last  = 1'b0;
    repeat (10) @(posedge in_support_if);
    rst_n <= 1'b1;
    repeat (RUN_CYCLES) begin
      @(posedge in_support_if);
      drive_cycle();
    end
    traffic_on = 1'b0;
    drain_buses();
    repeat (4) begin
      @(posedge in_support_if);
      drive_cycle();
    end
    @(negedge in_support_if);
    a_ff_once: assert (ff_count == 1)
      else begin
        errors++;
        $display("first_fetch pulsed %0d times instead of once", ff_count);
      end
    a_fd_again: assert (fd_count >= 2)
      else begin
        errors++;
        $display("first_debug_ins fired only %0d times, no debug re-entry seen", fd_count);
      end
    a_rae_seen: assert (rae_cycles > 0)
      else begin
        errors++;
        $display("req_after_exception never went high");
      end
    $display("run done: %0d errors, %0d first_fetch, %0d first_debug_ins, %0d exception cycles",
             errors, ff_count, fd_count, rae_cycles);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- design/support_logic.sv
`timescale 1ns/1ps

module support_logic (
  input  logic                     in_support_if,
  input  logic                     rst_n_i,
  input  support_pkg::obi_bus_t    instr_bus_i,
  input  support_pkg::obi_bus_t    data_bus_i,
  input  logic                     instr_integrity_i,
  input  logic                     data_integrity_i,
  input  support_pkg::core_ctrl_t  core_ctrl_i,
  input  support_pkg::retire_t     retire_i,
  output support_pkg::bus_phase_t  instr_phase_o,
  output support_pkg::bus_phase_t  data_phase_o,
  output support_pkg::resp_attr_t  attr_o,
  output support_pkg::core_event_t event_o
);

  // ----------------------------------------
  // bus phase monitors
  // ----------------------------------------
  obi_phase_monitor instr_phase_mon (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (instr_bus_i),
    .phase_o       (instr_phase_o)
  );

  obi_phase_monitor data_phase_mon (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (data_bus_i),
    .phase_o       (data_phase_o)
  );

  // ----------------------------------------
  // request attribute queues
  // ----------------------------------------
  // store flag on the data bus
  req_attribute_fifo req_was_store_fifo (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .req_i         (data_bus_i.req),
    .gnt_i         (data_bus_i.gnt),
    .rvalid_i      (data_bus_i.rvalid),
    .attr_i        (core_ctrl_i.req_is_store),
    .attr_o        (attr_o.req_was_store)
  );

  // integrity on the instruction bus
  req_attribute_fifo instr_integrity_fifo (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .req_i         (instr_bus_i.req),
    .gnt_i         (instr_bus_i.gnt),
    .rvalid_i      (instr_bus_i.rvalid),
    .attr_i        (instr_integrity_i),
    .attr_o        (attr_o.instr_req_had_integrity)
  );

  // integrity on the data bus
  req_attribute_fifo data_integrity_fifo (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .req_i         (data_bus_i.req),
    .gnt_i         (data_bus_i.gnt),
    .rvalid_i      (data_bus_i.rvalid),
    .attr_i        (data_integrity_i),
    .attr_o        (attr_o.data_req_had_integrity)
  );

  // grant parity errors follow their request to the response
  req_attribute_fifo instr_gntpar_fifo (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .req_i         (instr_bus_i.req),
    .gnt_i         (instr_bus_i.gnt),
    .rvalid_i      (instr_bus_i.rvalid),
    .attr_i        (instr_phase_o.gntpar_err),
    .attr_o        (attr_o.gntpar_error_in_response_instr)
  );

  req_attribute_fifo data_gntpar_fifo (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .req_i         (data_bus_i.req),
    .gnt_i         (data_bus_i.gnt),
    .rvalid_i      (data_bus_i.rvalid),
    .attr_i        (data_phase_o.gntpar_err),
    .attr_o        (attr_o.gntpar_error_in_response_data)
  );

  // core events
  core_event_tracker core_events (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .retire_i      (retire_i),
    .ctrl_i        (core_ctrl_i),
    .data_bus_i    (data_bus_i),
    .event_o       (event_o)
  );

endmodule

//--- design/core_event_tracker.sv
`timescale 1ns/1ps
`include "support_consts.svh"

module core_event_tracker (
  input  logic                     in_support_if,
  input  logic                     rst_n_i,
  input  support_pkg::retire_t     retire_i,
  input  support_pkg::core_ctrl_t  ctrl_i,
  input  support_pkg::obi_bus_t    data_bus_i,
  output support_pkg::core_event_t event_o
);

  localparam int HOLD_W = $clog2(`SL_DBG_HOLD + 1);

  // fetch_enable has been seen since reset
  logic              seen_enable_q;
  // last retirement was in debug mode
  logic              in_debug_q;
  // a dret retired last cycle
  logic              dret_seen_q;
  logic [HOLD_W-1:0] hold_cnt_q;
  logic              recorded_dbg_req_q;
  // trap taken and no clean retirement since
  logic              exception_active_q;
  // data bus grant in the previous cycle
  logic              data_gnt_q;
  logic              req_after_exception_q;
  logic              new_data_req;

  assign new_data_req = data_bus_i.req && data_gnt_q;

  assign event_o.first_fetch         = ctrl_i.fetch_enable && !seen_enable_q;
  assign event_o.first_debug_ins     = retire_i.valid && retire_i.dbg_mode && !in_debug_q;
  assign event_o.recorded_dbg_req    = recorded_dbg_req_q;
  assign event_o.req_after_exception = req_after_exception_q;

  // ----------------------------------------
  // fetch enable and debug entry
  // ----------------------------------------
  always_ff @(posedge in_support_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      seen_enable_q <= 1'b0;
      in_debug_q    <= 1'b0;
      dret_seen_q   <= 1'b0;
    end else begin
      if (ctrl_i.fetch_enable) begin
        seen_enable_q <= 1'b1;
      end
      if (retire_i.valid) begin
        in_debug_q <= retire_i.dbg_mode;
      end
      // leaving debug one cycle after a clean dret retires
      if (dret_seen_q) begin
        in_debug_q <= 1'b0;
      end
      dret_seen_q <= retire_i.valid && retire_i.is_dret && !retire_i.trap;
    end
  end

  // ----------------------------------------
  // debug request recording
  // ----------------------------------------
  always_ff @(posedge in_support_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      recorded_dbg_req_q <= 1'b0;
      hold_cnt_q         <= '0;
    end else if (retire_i.valid) begin
      if (ctrl_i.debug_req) begin
        recorded_dbg_req_q <= 1'b1;
        hold_cnt_q         <= HOLD_W'(1);
      end else if (hold_cnt_q != '0) begin
        hold_cnt_q <= hold_cnt_q - 1'b1;
      end else begin
        recorded_dbg_req_q <= 1'b0;
      end
    end else if (ctrl_i.debug_req) begin
      // no retirement yet so hold for the full window
      recorded_dbg_req_q <= 1'b1;
      hold_cnt_q         <= HOLD_W'(`SL_DBG_HOLD);
    end
  end

  // ----------------------------------------
  // data request after trap
  // ----------------------------------------
  always_ff @(posedge in_support_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exception_active_q    <= 1'b0;
      data_gnt_q            <= 1'b0;
      req_after_exception_q <= 1'b0;
    end else begin
      data_gnt_q <= data_bus_i.req && data_bus_i.gnt;
      if (ctrl_i.trap_taken) begin
        exception_active_q <= 1'b1;
        if (new_data_req) begin
          req_after_exception_q <= 1'b1;
        end
      end else if (retire_i.valid) begin
        exception_active_q    <= 1'b0;
        req_after_exception_q <= 1'b0;
      end else if (exception_active_q && new_data_req) begin
        req_after_exception_q <= 1'b1;
      end
    end
  end

  // debug entry marks the core as in debug from the next cycle on
  a_first_debug_in_dbg: assert property (@(posedge in_support_if) disable iff (!rst_n_i)
    event_o.first_debug_ins |-> retire_i.dbg_mode ##1 in_debug_q)
    else $error("core_event_tracker: first_debug_ins outside debug mode");

endmodule

//--- design/req_attribute_fifo.sv
`timescale 1ns/1ps
`include "support_consts.svh"

module req_attribute_fifo #(
  parameter int DEPTH = `SL_FIFO_DEPTH
) (
  input  logic in_support_if,
  input  logic rst_n_i,
  input  logic req_i,
  input  logic gnt_i,
  input  logic rvalid_i,
  input  logic attr_i,
  output logic attr_o
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  // one attribute bit per granted request
  logic [DEPTH-1:0] mem_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] fill_q;
  logic             push;
  logic             pop;

  assign push = req_i && gnt_i;
  assign pop  = rvalid_i;

  // oldest entry shows only alongside its response
  assign attr_o = pop && mem_q[rd_ptr_q];

  // storage
  always_ff @(posedge in_support_if) begin
    if (push) begin
      mem_q[wr_ptr_q] <= attr_i;
    end
  end

  // ----------------------------------------
  // pointers and fill level
  // ----------------------------------------
  always_ff @(posedge in_support_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      // pointers wrap at DEPTH, any depth works
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        fill_q <= fill_q + 1'b1;
      end else if (!push && pop) begin
        fill_q <= fill_q - 1'b1;
      end
    end
  end

  // the bus never has more outstanding requests than entries
  a_no_push_full: assert property (@(posedge in_support_if) disable iff (!rst_n_i)
    push && !pop |-> fill_q != CNT_W'(DEPTH))
    else $error("req_attribute_fifo: grant while queue full");

  // response only for a request granted in an earlier cycle
  a_no_pop_empty: assert property (@(posedge in_support_if) disable iff (!rst_n_i)
    pop |-> fill_q != '0)
    else $error("req_attribute_fifo: rvalid while queue empty");

endmodule

//--- design/obi_phase_monitor.sv
`timescale 1ns/1ps
`include "support_consts.svh"

module obi_phase_monitor (
  input  logic                    in_support_if,
  input  logic                    rst_n_i,
  input  support_pkg::obi_bus_t   bus_i,
  output support_pkg::bus_phase_t phase_o
);

  logic                 addr_ph_cont_q;
  logic                 resp_ph_cont_q;
  logic [`SL_CNT_W-1:0] outstanding_q;
  // parity error seen earlier in the same ungranted request
  logic                 gntpar_err_q;
  logic                 granted;
  logic                 gntpar_err;

  // address phase handshake
  assign granted = bus_i.req && bus_i.gnt;

  // gntpar must be the inverse of gnt while req is up
  assign gntpar_err = bus_i.req && ((bus_i.gnt == bus_i.gntpar) || gntpar_err_q);

  // ----------------------------------------
  // phase tracking
  // ----------------------------------------
  always_ff @(posedge in_support_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      addr_ph_cont_q <= 1'b0;
      resp_ph_cont_q <= 1'b0;
      outstanding_q  <= '0;
      gntpar_err_q   <= 1'b0;
    end else begin
      // request waiting for grant, address phase carries on
      addr_ph_cont_q <= bus_i.req && !bus_i.gnt;
      // something outstanding and no response yet
      resp_ph_cont_q <= (outstanding_q != '0) && !bus_i.rvalid;
      // grant and response in the same cycle cancel out
      if (granted && !bus_i.rvalid) begin
        outstanding_q <= outstanding_q + 1'b1;
      end else if (!granted && bus_i.rvalid) begin
        outstanding_q <= outstanding_q - 1'b1;
      end
      // keep the error only while the request is still pending
      gntpar_err_q <= bus_i.req && !bus_i.gnt && gntpar_err;
    end
  end

  assign phase_o.addr_ph_cont = addr_ph_cont_q;
  assign phase_o.resp_ph_cont = resp_ph_cont_q;
  assign phase_o.outstanding  = outstanding_q;
  assign phase_o.gntpar_err   = gntpar_err;

  // ----------------------------------------
  // bus protocol assumptions
  // ----------------------------------------
  // every response belongs to an earlier grant
  a_rvalid_has_outstanding: assert property (@(posedge in_support_if) disable iff (!rst_n_i)
    bus_i.rvalid |-> outstanding_q != '0)
    else $error("obi_phase_monitor: rvalid with nothing outstanding");

  // a pure grant must leave a nonzero count, i.e. no wrap
  a_outstanding_no_wrap: assert property (@(posedge in_support_if) disable iff (!rst_n_i)
    granted && !bus_i.rvalid |=> outstanding_q != '0)
    else $error("obi_phase_monitor: outstanding counter wrapped");

endmodule

//--- design/support_pkg.sv
`include "support_consts.svh"

package support_pkg;

  // one observed OBI bus
  typedef struct packed {
    logic req;
    logic gnt;
    logic gntpar;
    logic rvalid;
  } obi_bus_t;

  // phase monitor flags for one bus
  typedef struct packed {
    logic                 addr_ph_cont;
    logic                 resp_ph_cont;
    logic [`SL_CNT_W-1:0] outstanding;
    logic                 gntpar_err;
  } bus_phase_t;

  // retirement report from the core
  typedef struct packed {
    logic valid;
    logic dbg_mode;
    logic is_dret;
    logic trap;
  } retire_t;

  // core side levels and pulses
  // trap_taken pulses one cycle when pc jumps to an exception or bus-error vector
  typedef struct packed {
    logic fetch_enable;
    logic debug_req;
    logic trap_taken;
    logic req_is_store;
  } core_ctrl_t;

  // event tracker flags
  typedef struct packed {
    logic first_fetch;
    logic first_debug_ins;
    logic recorded_dbg_req;
    logic req_after_exception;
  } core_event_t;

  // request attributes returned with each response
  typedef struct packed {
    logic req_was_store;
    logic instr_req_had_integrity;
    logic data_req_had_integrity;
    logic gntpar_error_in_response_instr;
    logic gntpar_error_in_response_data;
  } resp_attr_t;

endpackage

//--- design/support_consts.svh
`ifndef SUPPORT_CONSTS_SVH
`define SUPPORT_CONSTS_SVH

// ----------------------------------------
// observation subsystem sizing
// ----------------------------------------

// width of the per-bus outstanding transaction counter
`define SL_CNT_W 3

// attribute queue depth, must cover the max outstanding count on a bus
`define SL_FIFO_DEPTH 4

// retirements a debug request stays recorded when seen without one
`define SL_DBG_HOLD 2

`endif
